/* flist.f */
verilog/dsp_pkg.sv
verilog/mac16_unit.sv
verilog/coef_bank.sv
verilog/scaler_output_stage.sv
verilog/gain_offset_top.sv
tb/gain_offset_sva.sv
tb/gain_offset_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module gain_offset_tb -f flist.f \
    -o gain_offset_sim > build.log 2>&1 \
    && ./obj_dir/gain_offset_sim > sim.log 2>&1 \
    || echo "Build or run ended with an error, see build.log and sim.log"

grep -q 'All tests passed!' sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tb/gain_offset_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module gain_offset_sva (
    input logic          clk,
    input logic          i_reset,
    input logic          i_valid,
    input logic          o_valid,
    input dsp_pkg::acc_t o_result,
    input logic          o_clip
);

    import dsp_pkg::*;

    // Range of a 16-bit signed sample
    localparam acc_t RANGE_MAX = 32'sd32767;
    localparam acc_t RANGE_MIN = -32'sd32768;

    valid_low_after_reset: assert property (
        @(posedge clk) i_reset |=> !o_valid
    ) else $error("o_valid high in the cycle after reset");

    // Fixed pipeline of three cycles
    valid_latency: assert property (
        @(posedge clk) disable iff (i_reset) o_valid == $past(i_valid, 3)
    ) else $error("o_valid does not match i_valid from three cycles earlier");

    clip_only_out_of_range: assert property (
        @(posedge clk) disable iff (i_reset)
        (o_valid && o_result <= RANGE_MAX && o_result >= RANGE_MIN) |-> !o_clip
    ) else $error("o_clip high while the full result fits in 16 bits");

endmodule

bind gain_offset_top gain_offset_sva gain_offset_sva_inst (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_valid  (i_valid),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_clip   (o_clip)
);

`default_nettype wire

/* tb/gain_offset_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module gain_offset_tb;

    import dsp_pkg::*;

    localparam int NUM_CHAN      = 4;
    localparam int CLK_HALF      = 10;
    localparam int DRIVE_DELAY   = 2;
    localparam int STREAM_LEN    = 32;
    localparam int DRAIN_TIMEOUT = 50;

    // Two channel bits are reported for four channels
    localparam logic [MAX_CHAN_W-1:0] CHAN_MASK = 4'h3;

    // One stimulus row with its expected output
    typedef struct packed {
        logic [MAX_CHAN_W-1:0] chan;
        sample_t               sample;
        logic                  we;
        logic [MAX_CHAN_W-1:0] wchan;
        coef_t                 wgain;
        coef_t                 woffset;
        acc_t                  full;
        sample_t               sat;
        logic                  clip;
    } stim_t;

    // Output expected for one sample in flight
    typedef struct packed {
        logic [MAX_CHAN_W-1:0] chan;
        acc_t                  full;
        sample_t               sat;
        logic                  clip;
        logic [31:0]           cycle;
    } expect_t;

    logic                  clk;
    logic                  i_reset;
    logic                  i_valid;
    sample_t               i_sample;
    logic [MAX_CHAN_W-1:0] i_chan;
    logic                  i_cfg_we;
    logic [MAX_CHAN_W-1:0] i_cfg_chan;
    coef_t                 i_cfg_gain;
    coef_t                 i_cfg_offset;
    logic                  o_valid;
    logic [MAX_CHAN_W-1:0] o_chan;
    acc_t                  o_result;
    sample_t               o_sat_sample;
    logic                  o_clip;

    stim_t   table_rows[$];
    string   table_names[$];
    expect_t expect_q[$];
    string   name_q[$];

    // Shadow copy of the coefficient bank
    int shadow_gain   [NUM_CHAN];
    int shadow_offset [NUM_CHAN];

    logic [31:0] cycle_count = '0;
    int          tests_sent  = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          stray_count = 0;
    logic        timed_out   = 1'b0;

    gain_offset_top #(
        .NUM_CHAN     (NUM_CHAN)
    ) gain_offset_top_inst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_sample     (i_sample),
        .i_chan       (i_chan),
        .i_cfg_we     (i_cfg_we),
        .i_cfg_chan   (i_cfg_chan),
        .i_cfg_gain   (i_cfg_gain),
        .i_cfg_offset (i_cfg_offset),
        .o_valid      (o_valid),
        .o_chan       (o_chan),
        .o_result     (o_result),
        .o_sat_sample (o_sat_sample),
        .o_clip       (o_clip)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // Counts rising edges, used for the latency check
    always @(posedge clk) begin
        cycle_count <= cycle_count + 32'd1;
    end

    function automatic sample_t clamp_to_16(input int value);
        if (value > 32767) begin
            return 16'sh7fff;
        end else if (value < -32768) begin
            return 16'sh8000;
        end
        return value[15:0];
    endfunction

    // Sample times gain plus offset, zero for a missing channel
    function automatic int model_full(input int chan, input int sample);
        if (chan >= NUM_CHAN) begin
            return 0;
        end
        return sample * shadow_gain[chan] + shadow_offset[chan];
    endfunction

    task automatic update_shadow(input int chan, input int gain, input int offset);
        if (chan < NUM_CHAN) begin
            shadow_gain[chan]   = gain;
            shadow_offset[chan] = offset;
        end
    endtask

    task automatic add_row(input string name, input int chan, input int sample,
                           input bit we, input int wchan, input int wgain,
                           input int woffset, input int full, input int sat,
                           input bit clip);
        stim_t row;
        row.chan    = chan[MAX_CHAN_W-1:0];
        row.sample  = sample[15:0];
        row.we      = we;
        row.wchan   = wchan[MAX_CHAN_W-1:0];
        row.wgain   = wgain[15:0];
        row.woffset = woffset[15:0];
        row.full    = full;
        row.sat     = sat[15:0];
        row.clip    = clip;
        table_rows.push_back(row);
        table_names.push_back(name);
    endtask

    task automatic build_table();
        // name, chan, sample, we, wchan, wgain, woffset, full, sat, clip
        add_row("reset_ch0", 0, 1234, 0, 0, 0, 0, 1234, 1234, 0);
        add_row("reset_ch1", 1, -500, 0, 0, 0, 0, -500, -500, 0);
        add_row("reset_ch2", 2, 32767, 0, 0, 0, 0, 32767, 32767, 0);
        add_row("reset_ch3", 3, -32768, 0, 0, 0, 0, -32768, -32768, 0);
        add_row("write_same_cycle", 0, 100, 1, 0, 3, -7, 100, 100, 0);
        add_row("write_next_cycle", 0, 100, 0, 0, 0, 0, 293, 293, 0);
        add_row("other_chan_kept", 1, 100, 1, 1, -2, 50, 100, 100, 0);
        add_row("neg_gain_pos_offset", 1, 1000, 0, 0, 0, 0, -1950, -1950, 0);
        add_row("neg_sample", 0, -40, 1, 2, 0, -300, -127, -127, 0);
        add_row("zero_gain", 2, 12345, 0, 0, 0, 0, -300, -300, 0);
        add_row("ch3_still_unity", 3, 77, 1, 3, 2, 0, 77, 77, 0);
        add_row("sat_pos_gain2", 3, 32767, 1, 3, 32767, 0, 65534, 32767, 1);
        add_row("sat_neg_full_scale", 3, -32768, 0, 0, 0, 0, -1073709056, -32768, 1);
        add_row("edge_neg_in_range", 1, 16409, 0, 0, 0, 0, -32768, -32768, 0);
        add_row("edge_neg_clip", 1, 16410, 0, 0, 0, 0, -32770, -32768, 1);
        add_row("edge_pos_clip", 0, 10925, 0, 0, 0, 0, 32768, 32767, 1);
        add_row("out_of_range_read", 5, 999, 0, 0, 0, 0, 0, 0, 0);
        add_row("out_of_range_write", 2, 10, 1, 9, 5, 5, -300, -300, 0);
        add_row("write_ignored", 1, 10, 0, 0, 0, 0, 30, 30, 0);
    endtask

    // One sample per call, sampled by the next rising edge
    task automatic drive_sample(input string name, input stim_t row);
        expect_t want;
        @(posedge clk);
        #DRIVE_DELAY;
        i_valid      = 1'b1;
        i_chan       = row.chan;
        i_sample     = row.sample;
        i_cfg_we     = row.we;
        i_cfg_chan   = row.wchan;
        i_cfg_gain   = row.wgain;
        i_cfg_offset = row.woffset;
        want.chan    = row.chan & CHAN_MASK;
        want.full    = row.full;
        want.sat     = row.sat;
        want.clip    = row.clip;
        want.cycle   = cycle_count + 32'd3;
        expect_q.push_back(want);
        name_q.push_back(name);
        tests_sent++;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #DRIVE_DELAY;
        i_valid  = 1'b0;
        i_cfg_we = 1'b0;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin : check_outputs
        expect_t want;
        string   test_name;
        int      errors;
        if (o_valid === 1'b1) begin
            if (expect_q.size() == 0) begin
                $display("ERROR: o_valid high at cycle %0d with no sample in flight",
                         cycle_count);
                stray_count++;
            end else begin
                want      = expect_q.pop_front();
                test_name = name_q.pop_front();
                errors    = 0;
                if (o_chan !== want.chan) begin
                    $display("CHECK FAILED %s o_chan: expected %0d, actual %0d",
                             test_name, want.chan, o_chan);
                    errors++;
                end
                if (o_result !== want.full) begin
                    $display("CHECK FAILED %s o_result: expected %0d, actual %0d",
                             test_name, $signed(want.full), $signed(o_result));
                    errors++;
                end
                if (o_sat_sample !== want.sat) begin
                    $display("CHECK FAILED %s o_sat_sample: expected %0d, actual %0d",
                             test_name, $signed(want.sat), $signed(o_sat_sample));
                    errors++;
                end
                if (o_clip !== want.clip) begin
                    $display("CHECK FAILED %s o_clip: expected %0b, actual %0b",
                             test_name, want.clip, o_clip);
                    errors++;
                end
                if (cycle_count != want.cycle) begin
                    $display("CHECK FAILED %s latency: expected cycle %0d, actual cycle %0d",
                             test_name, want.cycle, cycle_count);
                    errors++;
                end
                if (errors == 0) begin
                    pass_count++;
                    $display("PASS %s", test_name);
                end else begin
                    fail_count++;
                    $display("FAIL %s", test_name);
                end
            end
        end
    end

    initial begin : main
        stim_t       row;
        logic [31:0] raw;
        sample_t     smp;
        sample_t     sat_val;
        int          chan;
        int          full;
        int          wait_cycles;
        void'($urandom(2));
        i_reset      = 1'b1;
        i_valid      = 1'b0;
        i_sample     = '0;
        i_chan       = '0;
        i_cfg_we     = 1'b0;
        i_cfg_chan   = '0;
        i_cfg_gain   = '0;
        i_cfg_offset = '0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            update_shadow(c, 1, 0);
        end
        build_table();

        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        i_reset = 1'b0;

        // Directed rows, back to back
        for (int i = 0; i < table_rows.size(); i++) begin
            row = table_rows[i];
            drive_sample(table_names[i], row);
            if (row.we) begin
                update_shadow(int'(row.wchan), int'($signed(row.wgain)),
                              int'($signed(row.woffset)));
            end
        end

        // Random stream, channels 4 and 5 included
        for (int i = 0; i < STREAM_LEN; i++) begin
            raw     = $urandom;
            smp     = raw[15:0];
            chan    = int'($urandom % 6);
            full    = model_full(chan, int'(smp));
            sat_val = clamp_to_16(full);
            row         = '0;
            row.chan    = chan[MAX_CHAN_W-1:0];
            row.sample  = smp;
            row.full    = full;
            row.sat     = sat_val;
            row.clip    = (int'(sat_val) != full);
            drive_sample($sformatf("stream_%0d", i), row);
        end
        drive_idle();

        wait_cycles = 0;
        while (expect_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (expect_q.size() != 0) begin
            $display("ERROR: timed out waiting for %0d results that never appeared",
                     expect_q.size());
            timed_out = 1'b1;
        end
        // A few idle cycles to catch a stray strobe
        repeat (4) @(posedge clk);

        $display("Tests run: %0d, passed: %0d, failed: %0d, stray outputs: %0d",
                 tests_sent, pass_count, fail_count, stray_count);
        if (fail_count == 0 && stray_count == 0 && !timed_out &&
            pass_count == tests_sent) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/coef_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module coef_bank #(
    parameter int NUM_CHAN = 4
) (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_cfg_we,
    input  logic [dsp_pkg::MAX_CHAN_W-1:0] i_cfg_chan,
    input  dsp_pkg::coef_t                i_cfg_gain,
    input  dsp_pkg::coef_t                i_cfg_offset,
    input  logic [dsp_pkg::MAX_CHAN_W-1:0] i_chan,
    input  dsp_pkg::sample_t              i_sample,
    output dsp_pkg::mac_operands_t        o_operands
);

    import dsp_pkg::*;

    // Index bits needed to address NUM_CHAN entries
    localparam int IDX_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

    // Per-channel coefficient storage
    coef_t gain_regs   [NUM_CHAN];
    coef_t offset_regs [NUM_CHAN];

    logic             cfg_in_range;
    logic             rd_in_range;
    logic [IDX_W-1:0] cfg_idx;
    logic [IDX_W-1:0] rd_idx;

    coef_t rd_gain;
    coef_t rd_offset;

    // Channels at or above NUM_CHAN do not exist
    assign cfg_in_range = int'(i_cfg_chan) < NUM_CHAN;
    assign rd_in_range  = int'(i_chan) < NUM_CHAN;

    assign cfg_idx = i_cfg_chan[IDX_W-1:0];
    assign rd_idx  = i_chan[IDX_W-1:0];

    // Write port, new values visible from the next edge on
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                // Unity gain, no offset
                gain_regs[i]   <= coef_t'(1);
                offset_regs[i] <= '0;
            end
        end else if (i_cfg_we && cfg_in_range) begin
            gain_regs[cfg_idx]   <= i_cfg_gain;
            offset_regs[cfg_idx] <= i_cfg_offset;
        end
    end

    // Lookup for the sample's channel
    always_comb begin
        rd_gain   = '0;
        rd_offset = '0;
        if (rd_in_range) begin
            rd_gain   = gain_regs[rd_idx];
            rd_offset = offset_regs[rd_idx];
        end
    end

    // Operand bundle for the multiply-add
    always_comb begin
        o_operands.a = i_sample;
        o_operands.b = rd_gain;
        o_operands.c = rd_offset;
    end

endmodule

`default_nettype wire

/* verilog/dsp_pkg.sv */
`default_nettype none

package dsp_pkg;

    // Width of every channel field in the design
    localparam int MAX_CHAN_W = 4;

    // Register stages inside the multiply-add unit
    localparam int MAC_LATENCY = 2;

    // 16-bit signed input sample
    typedef logic signed [15:0] sample_t;

    // Gain or offset value, unity gain is 1
    typedef logic signed [15:0] coef_t;

    // Full multiply-add result, 16x16 product plus 16-bit offset fits here
    typedef logic signed [31:0] acc_t;

    // Operands presented to the multiply-add unit
    typedef struct packed {
        sample_t a;
        coef_t   b;
        coef_t   c;
    } mac_operands_t;

    // Registered result from the output stage
    typedef struct packed {
        logic                  valid;
        logic [MAX_CHAN_W-1:0] chan;
        acc_t                  full;
        sample_t               sat;
        logic                  clip;
    } mac_result_t;

endpackage

`default_nettype wire

/* verilog/gain_offset_top.sv */
`timescale 1ns/10ps
`default_nettype none

module gain_offset_top #(
    parameter int NUM_CHAN = 4
) (
    input  logic                           clk,
    input  logic                           i_reset,

    // Sample stream
    input  logic                           i_valid,
    input  dsp_pkg::sample_t               i_sample,
    input  logic [dsp_pkg::MAX_CHAN_W-1:0] i_chan,

    // Coefficient write port
    input  logic                           i_cfg_we,
    input  logic [dsp_pkg::MAX_CHAN_W-1:0] i_cfg_chan,
    input  dsp_pkg::coef_t                 i_cfg_gain,
    input  dsp_pkg::coef_t                 i_cfg_offset,

    // Result stream, three cycles behind the input
    output logic                           o_valid,
    output logic [dsp_pkg::MAX_CHAN_W-1:0] o_chan,
    output dsp_pkg::acc_t                  o_result,
    output dsp_pkg::sample_t               o_sat_sample,
    output logic                           o_clip
);

    import dsp_pkg::*;

    mac_operands_t operands;
    acc_t          mac_result;
    mac_result_t   out_bundle;

    // Coefficient lookup and operand assembly
    coef_bank #(
        .NUM_CHAN     (NUM_CHAN)
    ) coef_bank_inst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_cfg_we     (i_cfg_we),
        .i_cfg_chan   (i_cfg_chan),
        .i_cfg_gain   (i_cfg_gain),
        .i_cfg_offset (i_cfg_offset),
        .i_chan       (i_chan),
        .i_sample     (i_sample),
        .o_operands   (operands)
    );

    mac16_unit mac16_unit_inst (
        .clk        (clk),
        .i_operands (operands),
        .o_result   (mac_result)
    );

    // Valid and channel enter here and are delayed internally
    scaler_output_stage #(
        .NUM_CHAN (NUM_CHAN)
    ) scaler_output_stage_inst (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_valid  (i_valid),
        .i_chan   (i_chan),
        .i_result (mac_result),
        .o_out    (out_bundle)
    );

    assign o_valid      = out_bundle.valid;
    assign o_chan       = out_bundle.chan;
    assign o_result     = out_bundle.full;
    assign o_sat_sample = out_bundle.sat;
    assign o_clip       = out_bundle.clip;

endmodule

`default_nettype wire

/* verilog/mac16_unit.sv */
`timescale 1ns/10ps
`default_nettype none

// Behavioral model of the DSP block in its fixed configuration
// Signed A and B, add only, D unused, no accumulation
module mac16_unit (
    input  logic                   clk,
    input  dsp_pkg::mac_operands_t i_operands,
    output dsp_pkg::acc_t          o_result
);

    import dsp_pkg::*;

    // Input register stage, like A_REG/B_REG/C_REG enabled
    sample_t a_reg;
    coef_t   b_reg;
    coef_t   c_reg;

    // Output register stage
    acc_t    result_reg;

    // Combinational product and sum between the two stages
    acc_t    product;
    acc_t    offset_ext;
    acc_t    sum;

    // Stage 1 captures the operands every cycle
    always_ff @(posedge clk) begin
        a_reg <= i_operands.a;
        b_reg <= i_operands.b;
        c_reg <= i_operands.c;
    end

    // Signed 16x16 multiply, both sides extended to the full width first
    always_comb begin
        product = acc_t'(a_reg) * acc_t'(b_reg);
    end

    // Offset enters the adder sign-extended to 32 bits
    always_comb begin
        offset_ext = acc_t'(c_reg);
    end

    // Add only, the subtract control is fixed off
    always_comb begin
        sum = product + offset_ext;
    end

    // Stage 2 holds the finished result
    always_ff @(posedge clk) begin
        result_reg <= sum;
    end

    assign o_result = result_reg;

endmodule

`default_nettype wire

/* verilog/scaler_output_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module scaler_output_stage #(
    parameter int NUM_CHAN = 4
) (
    input  logic                           clk,
    input  logic                           i_reset,
    input  logic                           i_valid,
    input  logic [dsp_pkg::MAX_CHAN_W-1:0] i_chan,
    input  dsp_pkg::acc_t                  i_result,
    output dsp_pkg::mac_result_t           o_out
);

    import dsp_pkg::*;

    // Channel bits actually needed for NUM_CHAN channels
    localparam int CHAN_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;
    localparam logic [MAX_CHAN_W-1:0] CHAN_MASK = MAX_CHAN_W'((1 << CHAN_W) - 1);

    // Saturation limits of a 16-bit signed sample
    localparam sample_t SAT_MAX = 16'sh7fff;
    localparam sample_t SAT_MIN = 16'sh8000;

    // Delay line matching the multiply-add latency
    logic [MAC_LATENCY-1:0] valid_pipe;
    logic [MAX_CHAN_W-1:0]  chan_pipe [MAC_LATENCY];

    logic    fits_16;
    sample_t sat_value;

    // Output registers
    logic                  out_valid;
    logic [MAX_CHAN_W-1:0] out_chan;
    acc_t                  out_full;
    sample_t               out_sat;
    logic                  out_clip;

    // Valid strobe shift, cleared by reset
    always_ff @(posedge clk) begin
        if (i_reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= i_valid;
            for (int i = 1; i < MAC_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // Channel tag travels alongside
    always_ff @(posedge clk) begin
        chan_pipe[0] <= i_chan;
        for (int i = 1; i < MAC_LATENCY; i++) begin
            chan_pipe[i] <= chan_pipe[i-1];
        end
    end

    // Result fits in 16 bits when bits 31..15 all match the sign
    assign fits_16 = (&i_result[31:15]) || !(|i_result[31:15]);

    // Clamp toward the side of the sign
    always_comb begin
        if (fits_16) begin
            sat_value = i_result[15:0];
        end else if (i_result[31]) begin
            sat_value = SAT_MIN;
        end else begin
            sat_value = SAT_MAX;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= valid_pipe[MAC_LATENCY-1];
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        out_chan <= chan_pipe[MAC_LATENCY-1] & CHAN_MASK;
        out_full <= i_result;
        out_sat  <= sat_value;
        out_clip <= !fits_16;
    end

    always_comb begin
        o_out.valid = out_valid;
        o_out.chan  = out_chan;
        o_out.full  = out_full;
        o_out.sat   = out_sat;
        o_out.clip  = out_clip;
    end

endmodule

`default_nettype wire
